// File: Makefile
SIM  := obj_dir/Vtb_top
SRCS := $(wildcard common/*.sv common/*.svh rtl/*.sv operator/*.sv dv/*.sv)

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

$(SIM): sources.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module tb_top -Mdir obj_dir -o Vtb_top

clean:
	rm -rf obj_dir

// File: common/audio_pkg.sv
`default_nettype none

`include "opl3_config.svh"

package audio_pkg;

    // one stereo sample pair as sent in an i2s frame
    // left sits in the upper half so it is shifted out first
    typedef struct packed {
        logic signed [`SAMPLE_WIDTH-1:0] left;   // sent while ws is low
        logic signed [`SAMPLE_WIDTH-1:0] right;  // sent while ws is high
    } stereo_sample_t;

endpackage

`default_nettype wire

// File: common/opl3_config.svh
`ifndef OPL3_CONFIG_SVH
`define OPL3_CONFIG_SVH

// audio path
`define SAMPLE_WIDTH     16  // signed sample to the codec
`define SAMPLE_DIV       64  // clk cycles per sample, two per i2s bit

// phase accumulator
`define PHASE_WIDTH      20  // wraps freely
`define FNUM_WIDTH       10  // frequency number
`define BLOCK_WIDTH      3   // octave shift
`define MULT_WIDTH       4   // frequency multiplier, 0 stops the phase

// envelope and attenuation
`define ENV_WIDTH        4   // ar, dr, sl and rr fields
`define TL_WIDTH         3   // total level as extra right shift
`define ENV_LEVEL_WIDTH  9   // 0 is silent, 511 is full scale

`endif

// File: common/opl3_pkg.sv
`default_nettype none

`include "opl3_config.svh"

package opl3_pkg;

    // selectable operator shapes, computed and not table based
    typedef enum logic [1:0] {
        WS_TRIANGLE    = 2'd0,  // peak at quarter phase
        WS_SQUARE      = 2'd1,  // full swing
        WS_SAW         = 2'd2,  // ramp from -full to +full
        WS_HALF_SQUARE = 2'd3   // positive half only
    } waveform_t;

    // ADSR phases of the envelope generator
    typedef enum logic [2:0] {
        ENV_IDLE    = 3'd0,  // silent, waits for key-on
        ENV_ATTACK  = 3'd1,  // rising to max
        ENV_DECAY   = 3'd2,  // falling to sustain level
        ENV_SUSTAIN = 3'd3,  // held while key is down
        ENV_RELEASE = 3'd4   // falling to zero after key-off
    } env_state_t;

    // per operator settings, all static between strobes
    typedef struct packed {
        logic [`FNUM_WIDTH-1:0]  fnum;   // frequency number
        logic [`BLOCK_WIDTH-1:0] block;  // octave
        logic [`MULT_WIDTH-1:0]  mult;   // multiplier
        waveform_t               ws;     // wave select
        logic [`ENV_WIDTH-1:0]   ar;     // attack rate, level step / 4
        logic [`ENV_WIDTH-1:0]   dr;     // decay rate, level step
        logic [`ENV_WIDTH-1:0]   sl;     // sustain level in units of 32
        logic [`ENV_WIDTH-1:0]   rr;     // release rate, level step
        logic [`TL_WIDTH-1:0]    tl;     // total level shift
    } op_params_t;

    // the operator output is one signed sample
    typedef logic signed [`SAMPLE_WIDTH-1:0] op_sample_t;

endpackage

`default_nettype wire

// File: dv/tb_checker.sv
`timescale 1ns/100ps
`default_nettype none

module tb_checker (
    input wire clk,
    input wire rst_n,
    input wire sample_clk_en,
    input wire i2s_sclk,
    input wire i2s_ws,
    input wire i2s_sd
);

    // strobe is never two cycles long
    strobe_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        sample_clk_en |=> !sample_clk_en)
        else $error("sample strobe stayed high for more than one cycle");

    // bit clock runs at half the system clock
    sclk_toggles: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> (i2s_sclk != $past(i2s_sclk)))
        else $error("sclk did not toggle");

    // word select moves together with a falling bit clock
    ws_on_sclk_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(i2s_ws) |-> $fell(i2s_sclk))
        else $error("ws changed away from a falling sclk");

    // pins quiet while in reset
    pins_low_in_reset: assert property (@(posedge clk)
        !rst_n |-> (!i2s_sclk && !i2s_ws && !i2s_sd))
        else $error("i2s pins not low during reset");

endmodule

`default_nettype wire

// File: dv/tb_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_top;

    localparam int TIMEOUT = 200;                    // clocks allowed per frame wait

    logic clk, rst_n, kon_l, kon_r;
    opl3_pkg::op_params_t params_l, params_r;
    wire i2s_sclk, i2s_ws, i2s_sd;

    int                        m_phase [2];          // model phase per channel
    int                        m_level [2];          // model envelope level
    opl3_pkg::env_state_t      m_state [2];
    logic                      m_kprev [2];          // kon at the last step
    audio_pkg::stereo_sample_t exp_q [$];            // expected frames in order
    string                     name_q [$];           // test name per frame
    string                     test_name;
    int                        steps_pushed, frames_checked, error_count;
    logic [15:0]               lfsr;
    logic [31:0]               frame_sh;             // decoded bits, msb first
    logic                      sclk_last, ws_last, frame_pending;

    top_level u_dut (
        .clk(clk), .rst_n(rst_n), .params_l(params_l), .params_r(params_r),
        .kon_l(kon_l), .kon_r(kon_r),
        .i2s_sclk(i2s_sclk), .i2s_ws(i2s_ws), .i2s_sd(i2s_sd)
    );

    bind top_level tb_checker u_checker (
        .clk(clk), .rst_n(rst_n), .sample_clk_en(sample_clk_en),
        .i2s_sclk(i2s_sclk), .i2s_ws(i2s_ws), .i2s_sd(i2s_sd)
    );

    always #50 clk = ~clk;                           // 100 ns period

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
            error_count++;
            $display("=== FAIL ===");
            $fatal(1, "sample mismatch");
        end
    endtask

    // galois lfsr stepped once per bit handed out
    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            r = (r << 1) | lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic opl3_pkg::op_params_t make_params(input int fnum, block, mult, ws,
                                                         input int ar, dr, sl, rr, tl);
        opl3_pkg::op_params_t p;
        p.fnum = fnum;
        p.block = block;
        p.mult = mult;
        p.ws = opl3_pkg::waveform_t'(ws);
        p.ar = ar;
        p.dr = dr;
        p.sl = sl;
        p.rr = rr;
        p.tl = tl;
        return p;
    endfunction

    // one sample step of an operator from the ADSR and wave rules
    function automatic logic signed [15:0] model_step(input int ch,
                                                      input opl3_pkg::op_params_t p,
                                                      input logic kon);
        int f, lvl, pv, wave, ar, dr, rr, sl32;
        logic rise;
        f = p.fnum;
        ar = p.ar;
        dr = p.dr;
        rr = p.rr;
        sl32 = p.sl;
        sl32 = sl32 * 32;
        m_phase[ch] = (m_phase[ch] + (f << p.block) * p.mult) & 32'hFFFFF;
        rise = kon && !m_kprev[ch];
        m_kprev[ch] = kon;
        lvl = m_level[ch];
        case (m_state[ch])
            opl3_pkg::ENV_IDLE: if (rise) m_state[ch] = opl3_pkg::ENV_ATTACK;
            opl3_pkg::ENV_ATTACK: begin
                if (!kon) m_state[ch] = opl3_pkg::ENV_RELEASE;
                else if (ar != 0) begin
                    lvl = lvl + 4 * ar;
                    if (lvl >= 511) begin
                        lvl = 511;                   // top reached
                        m_state[ch] = opl3_pkg::ENV_DECAY;
                    end
                end
            end
            opl3_pkg::ENV_DECAY: begin
                if (!kon) m_state[ch] = opl3_pkg::ENV_RELEASE;
                else if (dr != 0) begin
                    if (lvl - dr > sl32) lvl = lvl - dr;
                    else begin
                        lvl = sl32;
                        m_state[ch] = opl3_pkg::ENV_SUSTAIN;
                    end
                end
            end
            opl3_pkg::ENV_SUSTAIN: if (!kon) m_state[ch] = opl3_pkg::ENV_RELEASE;
            default: begin                           // release
                if (rise) m_state[ch] = opl3_pkg::ENV_ATTACK;
                else if (rr != 0) begin
                    if (lvl > rr) lvl = lvl - rr;
                    else begin
                        lvl = 0;
                        m_state[ch] = opl3_pkg::ENV_IDLE;
                    end
                end
            end
        endcase
        m_level[ch] = lvl;
        pv = m_phase[ch] >> 10;                      // top 10 phase bits
        case (p.ws)
            opl3_pkg::WS_TRIANGLE: begin
                if (pv < 256) wave = pv * 128;
                else if (pv < 768) wave = (512 - pv) * 128;
                else wave = (pv - 1024) * 128;
                if (wave > 32767) wave = 32767;
                if (wave < -32767) wave = -32767;
            end
            opl3_pkg::WS_SQUARE: wave = (pv < 512) ? 32767 : -32767;
            opl3_pkg::WS_SAW: wave = (pv - 512) * 64;
            default: wave = (pv < 512) ? 32767 : 0;
        endcase
        return 16'((wave * lvl) >>> (9 + p.tl));
    endfunction

    task automatic wait_ws_fall();
        logic prev, fell;
        int cnt;
        prev = 1'b0;
        fell = 1'b0;
        cnt = 0;
        while (!fell && cnt < TIMEOUT) begin
            @(posedge clk);
            fell = prev && !i2s_ws;
            prev = i2s_ws;
            cnt++;
        end
        if (!fell) begin
            $display("timed out waiting for ws to fall");
            error_count++;
            $display("=== FAIL ===");
            $fatal(1, "no i2s frame");
        end
    endtask

    // new inputs land on the next strobe and show up two frames later
    task automatic run_steps(input int n, input opl3_pkg::op_params_t pl, pr,
                             input logic kl, kr);
        audio_pkg::stereo_sample_t e;
        for (int i = 0; i < n; i++) begin
            wait_ws_fall();
            params_l <= pl;
            params_r <= pr;
            kon_l <= kl;
            kon_r <= kr;
            e.left = model_step(0, pl, kl);
            e.right = model_step(1, pr, kr);
            exp_q.push_back(e);
            name_q.push_back(test_name);
            steps_pushed++;
        end
    endtask

    // i2s decoder where the rising edge after a ws fall carries the last bit of a frame
    always @(posedge clk) begin
        audio_pkg::stereo_sample_t e;
        string n;
        if (ws_last && !i2s_ws) frame_pending = 1'b1;
        if (!sclk_last && i2s_sclk) begin
            frame_sh = {frame_sh[30:0], i2s_sd};
            if (frame_pending) begin
                frame_pending = 1'b0;
                if (exp_q.size() > 0) begin
                    e = exp_q.pop_front();
                    n = name_q.pop_front();
                    check_value({n, " left"}, e.left, $signed(frame_sh[31:16]));
                    check_value({n, " right"}, e.right, $signed(frame_sh[15:0]));
                    frames_checked++;
                end
            end
        end
        sclk_last = i2s_sclk;
        ws_last = i2s_ws;
    end

    initial begin
        opl3_pkg::op_params_t pl, pr, zero;
        audio_pkg::stereo_sample_t e;
        logic kl, kr;
        int cnt;
        clk = 1'b0;
        rst_n = 1'b0;
        zero = '0;
        params_l = zero;
        params_r = zero;
        kon_l = 1'b0;
        kon_r = 1'b0;
        lfsr = 16'd77;
        {sclk_last, ws_last, frame_pending} = '0;
        frame_sh = '0;
        for (int c = 0; c < 2; c++) begin
            m_phase[c] = 0;
            m_level[c] = 0;
            m_state[c] = opl3_pkg::ENV_IDLE;
            m_kprev[c] = 1'b0;
        end
        test_name = "reset_silence";
        e = '0;
        exp_q.push_back(e);                          // frame 1 holds the reset output
        name_q.push_back(test_name);
        for (int s = 0; s < 2; s++) begin
            e.left = model_step(0, zero, 1'b0);      // strobes 1 and 2 see the reset inputs
            e.right = model_step(1, zero, 1'b0);
            exp_q.push_back(e);
            name_q.push_back(test_name);
        end
        steps_pushed = 3;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        run_steps(6, zero, zero, 1'b0, 1'b0);

        test_name = "phase_waveform";
        for (int w = 0; w < 4; w++) begin
            pl = make_params(300 + w * 100, w + 2, w + 1, w, 15, 0, 0, 15, 0);
            pr = make_params(1023, 7, (w == 3) ? 0 : 15, w, 15, 0, 0, 15, 0);
            run_steps(w == 0 ? 50 : 40, pl, pr, 1'b1, 1'b1);  // first pass ramps to 511
        end

        test_name = "envelope_adsr";
        run_steps(40, pl, pr, 1'b0, 1'b0);          // back to idle
        pl = make_params(100, 3, 1, 1, 4, 3, 8, 5, 0);
        pr = make_params(200, 2, 2, 2, 8, 6, 4, 9, 1);
        run_steps(140, pl, pr, 1'b1, 1'b1);
        run_steps(110, pl, pr, 1'b0, 1'b0);

        test_name = "retrigger_zero_rate";
        pl = make_params(150, 3, 2, 0, 15, 0, 0, 4, 0);
        run_steps(12, pl, pl, 1'b1, 1'b1);
        run_steps(20, pl, pl, 1'b0, 1'b0);
        pl.ar = 2;
        run_steps(15, pl, pl, 1'b1, 1'b1);          // attack from the release level
        pl.rr = 10;
        run_steps(5, pl, pl, 1'b0, 1'b0);
        pl.ar = 0;
        run_steps(20, pl, pl, 1'b1, 1'b1);          // frozen level

        test_name = "total_level_stereo";
        pl = make_params(250, 4, 3, 0, 15, 0, 0, 15, 3);
        pr = make_params(400, 3, 5, 2, 15, 0, 0, 15, 6);
        run_steps(15, pl, pr, 1'b1, 1'b0);
        run_steps(25, pl, pr, 1'b1, 1'b1);
        pl.tl = 6;
        pr.tl = 1;
        run_steps(20, pr, pl, 1'b0, 1'b1);          // swapped channels

        test_name = "random_run";
        kl = 1'b0;
        kr = 1'b0;
        for (int i = 0; i < 200; i++) begin
            pl = make_params(rand_bits(10), rand_bits(3), rand_bits(4), rand_bits(2),
                             rand_bits(4), rand_bits(4), rand_bits(4), rand_bits(4),
                             rand_bits(3));
            pr = make_params(rand_bits(10), rand_bits(3), rand_bits(4), rand_bits(2),
                             rand_bits(4), rand_bits(4), rand_bits(4), rand_bits(4),
                             rand_bits(3));
            if (rand_bits(3) == 0) kl = ~kl;         // occasional key change
            if (rand_bits(3) == 0) kr = ~kr;
            run_steps(1, pl, pr, kl, kr);
        end

        cnt = 0;
        while (frames_checked < steps_pushed && cnt < 10 * TIMEOUT) begin
            @(posedge clk);
            cnt++;
        end
        if (frames_checked < steps_pushed) begin
            $display("frames stopped arriving before all expected samples were checked");
            error_count++;
        end
        if (error_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("=== FAIL ===");
            $fatal(1, "errors found");
        end
    end

endmodule

`default_nettype wire

// File: operator/env_gen.sv
`timescale 1ns/100ps
`default_nettype none

`include "opl3_config.svh"

module env_gen (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            sample_clk_en,
    input  wire                            kon,
    input  opl3_pkg::op_params_t           params,
    output logic [`ENV_LEVEL_WIDTH-1:0]    level
);

    localparam int LW = `ENV_LEVEL_WIDTH;
    localparam logic [LW:0] LEVEL_MAX = {1'b0, {LW{1'b1}}};   // 511

    opl3_pkg::env_state_t state;       // ADSR phase
    logic                 kon_prev;    // kon seen at the last strobe
    logic                 kon_rise;    // new key-on
    logic [LW:0]          attack_sum;  // level + 4*ar with carry
    logic [LW-1:0]        sustain_lvl; // sl * 32
    logic [LW:0]          decay_floor; // sustain level + dr

    assign kon_rise    = kon & ~kon_prev;
    assign attack_sum  = {1'b0, level} + ((LW + 1)'(params.ar) << 2);
    assign sustain_lvl = LW'(params.sl) << 5;
    assign decay_floor = {1'b0, sustain_lvl} + (LW + 1)'(params.dr);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= opl3_pkg::ENV_IDLE;
            level    <= '0;
            kon_prev <= 1'b0;
        end else if (sample_clk_en) begin
            kon_prev <= kon;
            case (state)
                opl3_pkg::ENV_IDLE: begin
                    if (kon_rise) state <= opl3_pkg::ENV_ATTACK;
                end
                opl3_pkg::ENV_ATTACK: begin
                    if (!kon) begin
                        state <= opl3_pkg::ENV_RELEASE;
                    end else if (params.ar != '0) begin
                        if (attack_sum >= LEVEL_MAX) begin
                            level <= LEVEL_MAX[LW-1:0];     // saturate at top
                            state <= opl3_pkg::ENV_DECAY;
                        end else begin
                            level <= attack_sum[LW-1:0];
                        end
                    end
                end
                opl3_pkg::ENV_DECAY: begin
                    if (!kon) begin
                        state <= opl3_pkg::ENV_RELEASE;
                    end else if (params.dr != '0) begin
                        if ({1'b0, level} > decay_floor) begin
                            level <= level - LW'(params.dr);
                        end else begin
                            level <= sustain_lvl;           // clamp to sustain
                            state <= opl3_pkg::ENV_SUSTAIN;
                        end
                    end
                end
                opl3_pkg::ENV_SUSTAIN: begin
                    if (!kon) state <= opl3_pkg::ENV_RELEASE;  // level holds
                end
                opl3_pkg::ENV_RELEASE: begin
                    if (kon_rise) begin
                        state <= opl3_pkg::ENV_ATTACK;      // from current level
                    end else if (params.rr != '0) begin
                        if (level > LW'(params.rr)) begin
                            level <= level - LW'(params.rr);
                        end else begin
                            level <= '0;                    // floor at silence
                            state <= opl3_pkg::ENV_IDLE;
                        end
                    end
                end
                default: state <= opl3_pkg::ENV_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: operator/operator.sv
`timescale 1ns/100ps
`default_nettype none

`include "opl3_config.svh"

module operator (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    sample_clk_en,
    input  wire                    kon,
    input  opl3_pkg::op_params_t   params,
    output opl3_pkg::op_sample_t   out
);

    localparam int SW  = `SAMPLE_WIDTH;
    localparam int LW  = `ENV_LEVEL_WIDTH;
    localparam int P_W = 10;                                 // phase bits used
    localparam logic signed [17:0] CLAMP = 18'sd32767;

    logic [`PHASE_WIDTH-1:0] phase;
    logic [LW-1:0]           level;
    logic                    strobe_d;                       // phase and level updated
    logic signed [17:0]      p_s;                            // top phase bits, signed
    logic signed [17:0]      tri_raw;                        // before clamp
    logic signed [SW-1:0]    wave;                           // selected shape
    logic signed [SW+LW:0]   scaled;                         // wave * level

    phase_gen u_phase_gen (
        .clk(clk), .rst_n(rst_n), .sample_clk_en(sample_clk_en),
        .params(params), .phase(phase)
    );

    env_gen u_env_gen (
        .clk(clk), .rst_n(rst_n), .sample_clk_en(sample_clk_en),
        .kon(kon), .params(params), .level(level)
    );

    assign p_s = $signed({8'b0, phase[`PHASE_WIDTH-1 -: P_W]});

    always_comb begin
        if (p_s < 18'sd256) tri_raw = p_s <<< 7;             // rising quarter
        else if (p_s < 18'sd768) tri_raw = (18'sd512 - p_s) <<< 7;
        else tri_raw = (p_s - 18'sd1024) <<< 7;              // back to zero
        case (params.ws)
            opl3_pkg::WS_TRIANGLE: begin
                if (tri_raw > CLAMP) wave = SW'(CLAMP);
                else if (tri_raw < -CLAMP) wave = SW'(-CLAMP);
                else wave = SW'(tri_raw);
            end
            opl3_pkg::WS_SQUARE: wave = (p_s < 18'sd512) ? SW'(CLAMP) : SW'(-CLAMP);
            opl3_pkg::WS_SAW: wave = SW'((p_s - 18'sd512) <<< 6);
            default: wave = (p_s < 18'sd512) ? SW'(CLAMP) : '0;  // half square
        endcase
    end

    assign scaled = wave * $signed({1'b0, level});           // envelope scaling

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            strobe_d <= 1'b0;
            out      <= '0;
        end else begin
            strobe_d <= sample_clk_en;
            if (strobe_d) out <= SW'(scaled >>> (LW + params.tl));  // tl attenuation
        end
    end

endmodule

`default_nettype wire

// File: operator/phase_gen.sv
`timescale 1ns/100ps
`default_nettype none

`include "opl3_config.svh"

module phase_gen (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        sample_clk_en,
    input  opl3_pkg::op_params_t       params,
    output logic [`PHASE_WIDTH-1:0]    phase
);

    // fnum shifted by the largest block
    localparam int SHIFT_W = `FNUM_WIDTH + (1 << `BLOCK_WIDTH) - 1;
    localparam int PROD_W  = SHIFT_W + `MULT_WIDTH;

    logic [SHIFT_W-1:0] fnum_shifted;              // fnum << block
    logic [PROD_W-1:0]  inc_full;                  // times mult

    assign fnum_shifted = SHIFT_W'(params.fnum) << params.block;
    assign inc_full     = fnum_shifted * params.mult;

    // accumulate once per sample, upper bits of the product drop off
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= '0;
        end else if (sample_clk_en) begin
            phase <= phase + inc_full[`PHASE_WIDTH-1:0];  // wraps at 2^20
        end
    end

endmodule

`default_nettype wire

// File: rtl/clk_div.sv
`timescale 1ns/100ps
`default_nettype none

`include "opl3_config.svh"

module clk_div (
    input  wire  clk,
    input  wire  rst_n,
    output logic sample_clk_en     // one clk wide, every SAMPLE_DIV clocks
);

    localparam int CNT_W = $clog2(`SAMPLE_DIV);
    localparam logic [CNT_W-1:0] TERM = CNT_W'(`SAMPLE_DIV - 1);

    logic [CNT_W-1:0] cnt;         // free running sample counter

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (cnt == TERM) begin
            cnt <= '0;             // wrap at terminal count
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // high in the 64th cycle after reset and every 64 after that
    assign sample_clk_en = (cnt == TERM);

endmodule

`default_nettype wire

// File: rtl/i2s.sv
`timescale 1ns/100ps
`default_nettype none

`include "opl3_config.svh"

module i2s (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        sample_clk_en,
    input  audio_pkg::stereo_sample_t  sample,
    output logic                       i2s_sclk,
    output logic                       i2s_ws,
    output logic                       i2s_sd
);

    localparam int FRAME_W = 2 * `SAMPLE_WIDTH;    // 32 bits per frame
    localparam int BIT_W   = $clog2(FRAME_W);

    logic [FRAME_W-1:0] shreg;                     // msb is next bit out
    logic [BIT_W-1:0]   bit_cnt;                   // falling edges since strobe
    logic               sclk_fall;                 // sclk goes low this edge

    assign sclk_fall = i2s_sclk;

    // bit clock at half the system clock
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            i2s_sclk <= 1'b0;
        end else begin
            i2s_sclk <= ~i2s_sclk;
        end
    end

    // strobe lands on a falling sclk since the frame is an even clk count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shreg   <= '0;
            bit_cnt <= '0;
            i2s_ws  <= 1'b0;
            i2s_sd  <= 1'b0;
        end else if (sample_clk_en) begin
            i2s_sd  <= shreg[FRAME_W-1];           // right lsb of old frame
            shreg   <= sample;                     // latch new pair
            bit_cnt <= '0;
            i2s_ws  <= 1'b0;                       // left half begins
        end else if (sclk_fall) begin
            i2s_sd  <= shreg[FRAME_W-1];           // one sclk behind ws
            shreg   <= {shreg[FRAME_W-2:0], 1'b0};
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == BIT_W'(`SAMPLE_WIDTH - 1)) begin
                i2s_ws <= 1'b1;                    // right half begins
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/top_level.sv
`timescale 1ns/100ps
`default_nettype none

module top_level (
    input  wire                    clk,
    input  wire                    rst_n,
    input  opl3_pkg::op_params_t   params_l,
    input  opl3_pkg::op_params_t   params_r,
    input  wire                    kon_l,
    input  wire                    kon_r,
    output wire                    i2s_sclk,
    output wire                    i2s_ws,
    output wire                    i2s_sd
);

    wire                        sample_clk_en;   // one pulse per frame
    opl3_pkg::op_sample_t       op_out_l;        // left operator sample
    opl3_pkg::op_sample_t       op_out_r;        // right operator sample
    audio_pkg::stereo_sample_t  sample;          // pair for the serializer

    assign sample = '{left: op_out_l, right: op_out_r};

    clk_div u_clk_div (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_clk_en (sample_clk_en)
    );

    operator operator_l (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_clk_en (sample_clk_en),
        .kon           (kon_l),
        .params        (params_l),
        .out           (op_out_l)
    );

    operator operator_r (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_clk_en (sample_clk_en),
        .kon           (kon_r),
        .params        (params_r),
        .out           (op_out_r)
    );

    // frame n carries the sample of step n-1
    i2s u_i2s (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_clk_en (sample_clk_en),
        .sample        (sample),
        .i2s_sclk      (i2s_sclk),
        .i2s_ws        (i2s_ws),
        .i2s_sd        (i2s_sd)
    );

endmodule

`default_nettype wire

// File: sources.f
+incdir+common
common/opl3_pkg.sv
common/audio_pkg.sv
rtl/clk_div.sv
operator/phase_gen.sv
operator/env_gen.sv
operator/operator.sv
rtl/i2s.sv
rtl/top_level.sv
dv/tb_checker.sv
dv/tb_top.sv
